/* design/alu.sv */
`include "exe_cfg.svh"

module alu
	import data_pkg::*;
	import isa_pkg::*;
(
	input word_t alu_num1,
	input word_t alu_num2,
	input alu_op_t alucontrol,
	input dword_t hilo,
	input shamt_t sa,
	input word_t pcplus4,
	output word_t alu_out,
	output dword_t alu_out_64,
	output logic overflow,
	output logic zero,
	div_if.master dv,
	input logic stall_mem
);
	localparam int MSB = `XLEN - 1;

	word_t alu_ans;
	word_t imm_zext;	// low half of num2, zero extended
	logic ovf_add;
	logic ovf_sub;

	assign imm_zext = {16'b0, alu_num2[15:0]};

	always_comb begin
		case (alucontrol)
			AND: alu_ans = alu_num1 & alu_num2;
			OR: alu_ans = alu_num1 | alu_num2;
			XOR: alu_ans = alu_num1 ^ alu_num2;
			NOR: alu_ans = ~(alu_num1 | alu_num2);
			ANDI: alu_ans = alu_num1 & imm_zext;
			ORI: alu_ans = alu_num1 | imm_zext;
			XORI: alu_ans = alu_num1 ^ imm_zext;
			LUI: alu_ans = {alu_num2[15:0], 16'b0};

			SLL: alu_ans = alu_num2 << sa;
			SRL: alu_ans = alu_num2 >> sa;
			SRA: alu_ans = $signed(alu_num2) >>> sa;
			SLLV: alu_ans = alu_num2 << alu_num1[4:0];
			SRLV: alu_ans = alu_num2 >> alu_num1[4:0];
			SRAV: alu_ans = $signed(alu_num2) >>> alu_num1[4:0];

			MFHI: alu_ans = hilo[2*`XLEN-1:`XLEN];
			MFLO: alu_ans = hilo[`XLEN-1:0];

			ADD, ADDU, ADDI, ADDIU: alu_ans = alu_num1 + alu_num2;
			SUB, SUBU: alu_ans = alu_num1 - alu_num2;
			SLT, SLTI: alu_ans = word_t'($signed(alu_num1) < $signed(alu_num2));
			SLTU, SLTIU: alu_ans = word_t'(alu_num1 < alu_num2);

			J, JR: alu_ans = alu_num1 + alu_num2;
			// return address is pc+8, past the delay slot
			JAL, JALR, BLTZAL, BGEZAL: alu_ans = pcplus4 + word_t'(4);
			BEQ, BNE: alu_ans = alu_num1 - alu_num2;

			LB, LBU, LH, LHU, LW, SB, SH, SW: alu_ans = alu_num1 + alu_num2;	// effective address

			MTC0: alu_ans = alu_num2;
			default: alu_ans = '0;
		endcase
	end

	// 64-bit path, holds hilo unless the op replaces it
	always_comb begin
		alu_out_64 = hilo;
		case (alucontrol)
			MULT: alu_out_64 = $signed(alu_num1) * $signed(alu_num2);
			MULTU: alu_out_64 = {{`XLEN{1'b0}}, alu_num1} * {{`XLEN{1'b0}}, alu_num2};
			MTHI: alu_out_64 = {alu_num1, hilo[`XLEN-1:0]};
			MTLO: alu_out_64 = {hilo[2*`XLEN-1:`XLEN], alu_num1};
			DIV, DIVU: alu_out_64 = dv.result;
			default: alu_out_64 = hilo;
		endcase
	end

	// branch taken flag, else result is zero
	always_comb begin
		case (alucontrol)
			BEQ: zero = (alu_num1 == alu_num2);
			BNE: zero = (alu_num1 != alu_num2);
			BGTZ: zero = !alu_num1[MSB] && (alu_num1 != '0);
			BLEZ: zero = alu_num1[MSB] || (alu_num1 == '0);
			BLTZ, BLTZAL: zero = alu_num1[MSB];
			BGEZ, BGEZAL: zero = !alu_num1[MSB];
			default: zero = (alu_ans == '0);
		endcase
	end

	// same operand signs, result sign flipped
	assign ovf_add = ((alucontrol == ADD) || (alucontrol == ADDI))
		&& (alu_num1[MSB] == alu_num2[MSB]) && (alu_ans[MSB] != alu_num1[MSB]);
	// operand signs differ, result takes the subtrahend sign
	assign ovf_sub = (alucontrol == SUB)
		&& (alu_num1[MSB] != alu_num2[MSB]) && (alu_ans[MSB] != alu_num1[MSB]);
	assign overflow = ovf_add || ovf_sub;

	assign alu_out = overflow ? '0 : alu_ans;

	// divide request, held while the op sits in this stage
	assign dv.a = alu_num1;
	assign dv.b = alu_num2;
	assign dv.sign = (alucontrol == DIV);
	assign dv.opn_valid = (alucontrol == DIV) || (alucontrol == DIVU);
	assign dv.res_ready = dv.opn_valid && !stall_mem;	// memory stage free to advance

endmodule

/* design/data_pkg.sv */
`include "exe_cfg.svh"

package data_pkg;

	// one register value
	typedef logic [`XLEN-1:0] word_t;

	// HI in the upper word, LO in the lower
	typedef logic [2*`XLEN-1:0] dword_t;

	// shift amount field of the instruction
	typedef logic [4:0] shamt_t;

endpackage

/* design/div.sv */
`include "exe_cfg.svh"

module div
	import data_pkg::*;
(
	input logic clk,
	input logic reset,
	div_if.slave dv
);
	localparam int unsigned ITERS = `DIV_ITERS;
	localparam int unsigned CNT_W = $clog2(ITERS);

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		DONE
	} div_state_t;

	div_state_t state;
	logic [CNT_W-1:0] cnt;	// iteration index
	word_t rem_q;	// partial remainder
	word_t quo_q;	// dividend bits out, quotient bits in
	word_t dsr_q;	// divisor magnitude
	logic neg_quo;
	logic neg_rem;

	logic a_neg;
	logic b_neg;
	word_t a_abs;
	word_t b_abs;
	logic [`XLEN:0] rem_shift;
	logic [`XLEN:0] rem_diff;
	word_t rem_nxt;
	word_t quo_nxt;
	logic last;

	assign a_neg = dv.sign && dv.a[`XLEN-1];
	assign b_neg = dv.sign && dv.b[`XLEN-1];
	assign a_abs = a_neg ? -dv.a : dv.a;
	assign b_abs = b_neg ? -dv.b : dv.b;
	assign last = (cnt == CNT_W'(ITERS - 1));

	// one restoring step
	always_comb begin
		rem_shift = {rem_q, quo_q[`XLEN-1]};
		rem_diff = rem_shift - {1'b0, dsr_q};
		if (rem_diff[`XLEN]) begin	// borrow, keep shifted value
			rem_nxt = rem_shift[`XLEN-1:0];
			quo_nxt = {quo_q[`XLEN-2:0], 1'b0};
		end else begin
			rem_nxt = rem_diff[`XLEN-1:0];
			quo_nxt = {quo_q[`XLEN-2:0], 1'b1};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (dv.opn_valid) begin
						state <= BUSY;
						cnt <= '0;
					end
				end
				BUSY: begin
					cnt <= cnt + 1'b1;
					if (last)
						state <= DONE;
				end
				DONE: begin
					if (dv.res_ready)	// result taken
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && dv.opn_valid) begin
			rem_q <= '0;
			quo_q <= a_abs;
			dsr_q <= b_abs;
			neg_quo <= a_neg ^ b_neg;
			neg_rem <= a_neg;	// remainder follows the dividend
		end else if (state == BUSY) begin
			if (last) begin
				quo_q <= neg_quo ? -quo_nxt : quo_nxt;
				rem_q <= neg_rem ? -rem_nxt : rem_nxt;
			end else begin
				quo_q <= quo_nxt;
				rem_q <= rem_nxt;
			end
		end
	end

	assign dv.res_valid = (state == DONE);
	assign dv.result = {rem_q, quo_q};

endmodule

/* design/div_if.sv */
interface div_if
	import data_pkg::*;
();
	word_t a;	// dividend
	word_t b;	// divisor
	logic sign;	// signed divide
	logic opn_valid;
	logic res_ready;
	logic res_valid;
	dword_t result;	// remainder in HI, quotient in LO

	// requester side
	modport master (
		output a, b, sign, opn_valid, res_ready,
		input res_valid, result
	);

	// divider side
	modport slave (
		input a, b, sign, opn_valid, res_ready,
		output res_valid, result
	);

endinterface

/* design/exe_cfg.svh */
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// data word width in bits
`define XLEN 32

// one quotient bit per iteration
`define DIV_ITERS `XLEN

`endif

/* design/exe_stage.sv */
module exe_stage
	import data_pkg::*;
	import isa_pkg::*;
(
	input logic clk,
	input logic reset,
	input word_t alu_num1,
	input word_t alu_num2,
	input alu_op_t alucontrol,
	input shamt_t sa,
	input word_t pcplus4,
	input logic flush,
	input logic stall_mem,
	output word_t alu_out,
	output dword_t hilo,
	output logic overflow,
	output logic zero,
	output logic div_stall
);
	dword_t alu_out_64;
	logic div_reset;
	logic stage_stall;

	div_if dv ();

	alu u_alu (
		.alu_num1 (alu_num1),
		.alu_num2 (alu_num2),
		.alucontrol (alucontrol),
		.hilo (hilo),
		.sa (sa),
		.pcplus4 (pcplus4),
		.alu_out (alu_out),
		.alu_out_64 (alu_out_64),
		.overflow (overflow),
		.zero (zero),
		.dv (dv.master),
		.stall_mem (stall_mem)
	);

	// flush aborts a divide in flight
	assign div_reset = reset || flush;

	div u_div (
		.clk (clk),
		.reset (div_reset),
		.dv (dv.slave)
	);

	// hold the stage until the quotient is handed over
	assign div_stall = dv.opn_valid && !(dv.res_valid && dv.res_ready);
	assign stage_stall = div_stall || stall_mem;

	hilo_reg u_hilo_reg (
		.clk (clk),
		.reset (reset),
		.op (alucontrol),
		.stall (stage_stall),
		.flush (flush),
		.wdata (alu_out_64),
		.hilo (hilo)
	);

endmodule

/* design/hilo_reg.sv */
module hilo_reg
	import data_pkg::*;
	import isa_pkg::*;
(
	input logic clk,
	input logic reset,
	input alu_op_t op,
	input logic stall,
	input logic flush,
	input dword_t wdata,
	output dword_t hilo
);
	logic hilo_op;	// op writes HI/LO
	logic wr_en;

	always_comb begin
		case (op)
			MULT, MULTU, DIV, DIVU, MTHI, MTLO: hilo_op = 1'b1;
			default: hilo_op = 1'b0;
		endcase
	end

	assign wr_en = hilo_op && !stall && !flush;

	always_ff @(posedge clk) begin
		if (reset)
			hilo <= '0;
		else if (wr_en)
			hilo <= wdata;
	end

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

	// ALU control field, one code per instruction class
	typedef enum logic [7:0] {
		NOP = 8'h00,	// no operation

		// logic
		AND,
		OR,
		XOR,
		NOR,
		ANDI,
		ORI,
		XORI,
		LUI,

		// shifts
		SLL, SRL, SRA,
		SLLV, SRLV, SRAV,

		// HI/LO moves
		MFHI, MFLO, MTHI, MTLO,

		// arithmetic
		ADD, ADDU, SUB, SUBU, ADDI, ADDIU,
		SLT, SLTU, SLTI, SLTIU,
		MULT, MULTU, DIV, DIVU,

		// jumps and branches
		J, JR, JAL, JALR,
		BEQ, BNE, BGTZ, BLEZ,
		BLTZ, BGEZ, BLTZAL, BGEZAL,

		// loads and stores, address only
		LB, LBU, LH, LHU, LW,
		SB, SH, SW,

		// privileged
		MTC0, ERET
	} alu_op_t;

endpackage

/* list.f */
+incdir+design
design/isa_pkg.sv
design/data_pkg.sv
design/div_if.sv
design/alu.sv
design/div.sv
design/hilo_reg.sv
design/exe_stage.sv
testbench/tb_exe_stage.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_exe_stage \
	-o sim_exe_stage || exit 1
out=$(./obj_dir/sim_exe_stage)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

/* testbench/tb_exe_stage.sv */
`include "exe_cfg.svh"

module tb_exe_stage
	import data_pkg::*;
	import isa_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RAND = 120;
	localparam int N_BR = 40;
	localparam int N_DIV = 10;
	localparam int TOTAL_OPS = N_RAND + N_BR + N_DIV + 40;
	localparam int WAIT_MAX = `DIV_ITERS + 4;	// cycles allowed for div_stall to fall

	logic clk = 1'b0;
	logic reset;
	word_t alu_num1;
	word_t alu_num2;
	alu_op_t alucontrol;
	shamt_t sa;
	word_t pcplus4;
	logic flush;
	logic stall_mem;
	word_t alu_out;
	dword_t hilo;
	logic overflow;
	logic zero;
	logic div_stall;

	word_t seed = 32'hd04b_5f51;
	dword_t model_hilo = '0;	// expected HI/LO contents
	word_t exp_out;
	logic exp_ovf;
	logic exp_zero;
	logic chk_alu;
	logic chk_out;
	int checks = 0;
	int errors = 0;
	int ck_mark = 0;
	int er_mark = 0;
	event check_ev;

	alu_op_t rand_ops [35] = '{AND, OR, XOR, NOR, ANDI, ORI, XORI, LUI,
		SLL, SRL, SRA, SLLV, SRLV, SRAV, ADD, ADDU, SUB, SUBU, ADDI, ADDIU,
		SLT, SLTU, SLTI, SLTIU, LB, LBU, LH, LHU, LW, SB, SH, SW, JAL, JALR, BLTZAL};
	alu_op_t br_ops [8] = '{BEQ, BNE, BGTZ, BLEZ, BLTZ, BGEZ, BLTZAL, BGEZAL};
	word_t ov_a [5] = '{32'h7fff_ffff, 32'h8000_0000, 32'h4000_0000,
		32'h8000_0000, 32'h7fff_ffff};
	word_t ov_b [5] = '{32'h0000_0001, 32'hffff_ffff, 32'h4000_0000,
		32'h0000_0001, 32'hffff_ffff};

	exe_stage UUT (
		.clk (clk),
		.reset (reset),
		.alu_num1 (alu_num1),
		.alu_num2 (alu_num2),
		.alucontrol (alucontrol),
		.sa (sa),
		.pcplus4 (pcplus4),
		.flush (flush),
		.stall_mem (stall_mem),
		.alu_out (alu_out),
		.hilo (hilo),
		.overflow (overflow),
		.zero (zero),
		.div_stall (div_stall)
	);

	always #10 clk = ~clk;

	function automatic word_t next_rand();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	// returns {overflow, zero, alu_out}
	function automatic logic [`XLEN+1:0] ref_exec(alu_op_t op, word_t a, word_t b, shamt_t s,
			word_t pc, dword_t hl);
		word_t r;
		logic z;
		logic v;
		longint wide;
		v = 1'b0;
		case (op)
			AND: r = a & b;
			OR: r = a | b;
			XOR: r = a ^ b;
			NOR: r = ~(a | b);
			ANDI: r = a & {16'h0, b[15:0]};
			ORI: r = a | {16'h0, b[15:0]};
			XORI: r = a ^ {16'h0, b[15:0]};
			LUI: r = {b[15:0], 16'h0};
			SLL: r = b << s;
			SRL: r = b >> s;
			SRA: r = $signed(b) >>> s;
			SLLV: r = b << a[4:0];
			SRLV: r = b >> a[4:0];
			SRAV: r = $signed(b) >>> a[4:0];
			MFHI: r = hl[2*`XLEN-1:`XLEN];
			MFLO: r = hl[`XLEN-1:0];
			ADD, ADDI, SUB: begin
				wide = (op == SUB) ? longint'($signed(a)) - longint'($signed(b))
					: longint'($signed(a)) + longint'($signed(b));
				r = word_t'(wide);
				v = (wide != longint'($signed(r)));	// sum left the signed range
			end
			ADDU, ADDIU, LB, LBU, LH, LHU, LW, SB, SH, SW: r = a + b;
			SUBU: r = a - b;
			SLT, SLTI: r = word_t'($signed(a) < $signed(b));
			SLTU, SLTIU: r = word_t'(a < b);
			JAL, JALR, BLTZAL, BGEZAL: r = pc + 32'd4;
			default: r = '0;
		endcase
		case (op)
			BEQ: z = (a == b);
			BNE: z = (a != b);
			BGTZ: z = ($signed(a) > 0);
			BLEZ: z = ($signed(a) <= 0);
			BLTZ, BLTZAL: z = ($signed(a) < 0);
			BGEZ, BGEZAL: z = ($signed(a) >= 0);
			default: z = (r == '0);
		endcase
		return {v, z, (v ? word_t'(0) : r)};
	endfunction

	// comparator, fired at the falling edge
	always @(check_ev) begin
		checks++;
		assert (hilo === model_hilo) else begin
			$display("Fail hilo: expected %h, got %h", model_hilo, hilo);
			errors++;
		end
		if (chk_alu) begin
			if (chk_out)
				assert (alu_out === exp_out) else begin
					$display("Fail alu_out (%s): expected %h, got %h", alucontrol.name(),
						exp_out, alu_out);
					errors++;
				end
			assert (overflow === exp_ovf) else begin
				$display("Fail overflow (%s): expected %h, got %h", alucontrol.name(),
					exp_ovf, overflow);
				errors++;
			end
			assert (zero === exp_zero) else begin
				$display("Fail zero (%s): expected %h, got %h", alucontrol.name(),
					exp_zero, zero);
				errors++;
			end
		end
	end

	task automatic drive(alu_op_t op, word_t a, word_t b, logic stl);
		@(posedge clk);
		alucontrol <= op;
		alu_num1 <= a;
		alu_num2 <= b;
		sa <= shamt_t'(next_rand());
		pcplus4 <= next_rand() & ~word_t'(3);
		stall_mem <= stl;
	endtask

	task automatic post_check(logic alu_en, logic out_en);
		@(negedge clk);
		{exp_ovf, exp_zero, exp_out} = ref_exec(alucontrol, alu_num1, alu_num2, sa,
			pcplus4, model_hilo);
		chk_alu = alu_en;
		chk_out = out_en;
		-> check_ev;
	endtask

	task automatic run_op(alu_op_t op, word_t a, word_t b, logic out_en);
		drive(op, a, b, 1'b0);
		post_check(1'b1, out_en);
	endtask

	task automatic write_hilo(alu_op_t op, word_t a, word_t b, logic stl);
		dword_t nv;
		case (op)
			// low half of the product of sign extended operands
			MULT: nv = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{b[`XLEN-1]}}, b};
			MULTU: nv = dword_t'(a) * dword_t'(b);
			MTHI: nv = {a, model_hilo[`XLEN-1:0]};
			MTLO: nv = {model_hilo[2*`XLEN-1:`XLEN], a};
			default: nv = model_hilo;
		endcase
		drive(op, a, b, stl);
		post_check(1'b0, 1'b0);
		drive(NOP, '0, '0, 1'b0);
		if (!stl)
			model_hilo = nv;
		post_check(1'b0, 1'b0);
	endtask

	task automatic do_div(alu_op_t op, word_t a, word_t b, int hold);
		word_t q;
		word_t r;
		int n;
		if (op == DIV) begin
			q = word_t'($signed(a) / $signed(b));
			r = word_t'($signed(a) % $signed(b));
		end else begin
			q = a / b;
			r = a % b;
		end
		drive(op, a, b, hold > 0);
		@(negedge clk);
		checks++;
		assert (div_stall === 1'b1) else begin
			$display("Fail div_stall (%s): expected %h, got %h", op.name(), 1'b1, div_stall);
			errors++;
		end
		repeat (hold) begin
			post_check(1'b0, 1'b0);
			assert (div_stall === 1'b1) else begin
				$display("Fail div_stall (%s): expected %h, got %h", op.name(), 1'b1,
					div_stall);
				errors++;
			end
		end
		if (hold > 0) begin
			@(posedge clk);
			stall_mem <= 1'b0;
		end
		n = 0;
		@(negedge clk);
		while (div_stall === 1'b1 && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		checks++;
		assert (div_stall === 1'b0) else begin
			$display("div_stall still high %0d cycles into %s", n, op.name());
			errors++;
		end
		drive(NOP, '0, '0, 1'b0);
		model_hilo = {r, q};	// remainder in HI
		post_check(1'b0, 1'b0);
	endtask

	task automatic finish_test(string name);
		@(posedge clk);
		$display("%s: %0d checks, %0d errors", name, checks - ck_mark, errors - er_mark);
		ck_mark = checks;
		er_mark = errors;
	endtask

	initial begin
		repeat (10 + TOTAL_OPS * (`DIV_ITERS + 4) + 200) @(posedge clk);
		$display("timeout: run did not finish in the expected number of cycles");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		int i;
		alu_op_t op;
		word_t a;
		word_t b;
		reset = 1'b1;
		alu_num1 = '0;
		alu_num2 = '0;
		alucontrol = NOP;
		sa = '0;
		pcplus4 = '0;
		flush = 1'b0;
		stall_mem = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		post_check(1'b0, 1'b0);	// hilo cleared by reset
		finish_test("reset");

		for (i = 0; i < N_RAND; i++) begin
			op = rand_ops[next_rand() % $size(rand_ops)];
			run_op(op, next_rand(), next_rand(), 1'b1);
		end
		finish_test("random single-cycle ops");

		for (i = 0; i < 5; i++) begin
			if (i < 3) begin
				run_op(ADD, ov_a[i], ov_b[i], 1'b1);
				run_op(ADDI, ov_a[i], ov_b[i], 1'b1);
				run_op(ADDU, ov_a[i], ov_b[i], 1'b1);
			end else begin
				run_op(SUB, ov_a[i], ov_b[i], 1'b1);
				run_op(SUBU, ov_a[i], ov_b[i], 1'b1);
			end
		end
		finish_test("overflow");

		for (i = 0; i < N_BR; i++) begin
			op = br_ops[i % 8];
			a = next_rand();
			b = next_rand();
			case ((i / 8) % 5)
				0: a = '0;
				1: a = (a >> 1) | 32'd1;	// positive
				2: a = a | 32'h8000_0000;	// negative
				4: b = a;
				default: ;
			endcase
			run_op(op, a, b, (op == BLTZAL) || (op == BGEZAL));
		end
		finish_test("branch conditions");

		write_hilo(MULT, 32'hffff_fff9, 32'h0000_1234, 1'b0);
		write_hilo(MULT, next_rand(), next_rand(), 1'b0);
		write_hilo(MULTU, next_rand(), next_rand(), 1'b0);
		write_hilo(MTHI, next_rand(), '0, 1'b0);
		run_op(MFHI, '0, '0, 1'b1);
		write_hilo(MTLO, next_rand(), '0, 1'b0);
		run_op(MFLO, '0, '0, 1'b1);
		write_hilo(MTHI, next_rand(), '0, 1'b1);	// stalled, no write
		write_hilo(MULTU, next_rand(), next_rand(), 1'b1);
		run_op(MFHI, '0, '0, 1'b1);
		run_op(MFLO, '0, '0, 1'b1);
		finish_test("hilo path");

		do_div(DIV, 32'hffff_ff85, 32'h0000_0007, 0);
		for (i = 0; i < N_DIV; i++) begin
			a = next_rand();
			b = next_rand();
			b = b >> b[4:0];	// spread divisor sizes
			if (b == '0)
				b = 32'd1;
			do_div((i % 2) ? DIVU : DIV, a, b, 0);
		end
		do_div(DIV, next_rand(), 32'h0000_0013, `DIV_ITERS + 6);
		do_div(DIVU, next_rand(), 32'h0001_0003, `DIV_ITERS + 6);
		finish_test("division");

		drive(DIV, next_rand(), 32'h0000_0005, 1'b0);
		repeat (`DIV_ITERS / 2) @(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		alucontrol <= NOP;
		post_check(1'b0, 1'b0);
		do_div(DIV, next_rand(), 32'hffff_fffd, 0);
		drive(MULT, next_rand(), next_rand(), 1'b0);
		flush <= 1'b1;
		post_check(1'b0, 1'b0);
		drive(NOP, '0, '0, 1'b0);
		flush <= 1'b0;
		post_check(1'b0, 1'b0);	// product dropped by flush
		finish_test("flush");

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
